/* periph_pkg.sv */
// Bus request and register write structs, address map and register offsets.

package periph_pkg;

    // One request on the peripheral bus.
    // Addresses are byte addresses inside the 4 KiB peripheral window.
    typedef struct packed {
        logic        sel;
        logic        we;
        logic [11:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    // One register write from the decoder to a block.
    // The offset also selects the read-back word of the block.
    typedef struct packed {
        logic [3:0]  off;
        logic [31:0] data;
    } reg_wr_t;

    // Base of the GPIO register block.
    localparam logic [11:0] GPIO_BASE  = 12'h000;

    // Base of the first PWM channel.
    localparam logic [11:0] PWM_BASE   = 12'h100;

    // Byte span of one PWM channel, four words.
    localparam logic [11:0] PWM_STRIDE = 12'h010;

    // GPIO word offsets.
    localparam logic [3:0] GPIO_OUT = 4'd0;
    localparam logic [3:0] GPIO_OE  = 4'd1;
    // Read only, synchronized pins.
    localparam logic [3:0] GPIO_IN  = 4'd2;
    localparam logic [3:0] GPIO_SEL = 4'd3;

    // PWM word offsets.
    localparam logic [3:0] PWM_PERIOD = 4'd0;
    localparam logic [3:0] PWM_DUTY   = 4'd1;
    localparam logic [3:0] PWM_EN     = 4'd2;
    // Read only, live counter value.
    localparam logic [3:0] PWM_COUNT  = 4'd3;

endpackage

/* periph_decoder.sv */
// Peripheral bus decoder with write strobes and registered read-back.

`timescale 1ns/1ns

module periph_decoder #(
    // Number of PWM channels behind the decoder.
    parameter int num_pwm   = 4,
    // PWM counter width.
    parameter int pwm_width = 16
)(
    input  logic                            clk,
    input  logic                            rst,

    // Request from the CPU side.
    input  periph_pkg::bus_req_t            req,

    // Shared write word and per-block strobes.
    output periph_pkg::reg_wr_t             wr,
    output logic                            gpio_we,
    output logic [num_pwm-1:0]              pwm_we,

    // Read words of the blocks for the current offset.
    input  logic [31:0]                     gpio_rdata,
    input  logic [num_pwm-1:0][31:0]        pwm_rdata,

    // Read data, valid one cycle after the read strobe.
    output logic [31:0]                     rdata
);
    // Channel registers never hold more than pwm_width bits.
    localparam logic [31:0] data_mask = (pwm_width >= 32) ? 32'hffff_ffff :
                                        32'((64'd1 << pwm_width) - 64'd1);

    logic               gpio_hit;
    logic [num_pwm-1:0] pwm_hit;
    logic [31:0]        read_word;

    // Block selection on the upper address bits.
    assign gpio_hit = req.addr[11:4] == periph_pkg::GPIO_BASE[11:4];

    for (genvar i = 0; i < num_pwm; i++) begin : g_hit
        localparam logic [11:0] chan_base =
            periph_pkg::PWM_BASE + 12'(i) * periph_pkg::PWM_STRIDE;
        assign pwm_hit[i] = req.addr[11:4] == chan_base[11:4];
    end

    // Word offset inside a four word window.
    assign wr.off  = {2'b00, req.addr[3:2]};
    assign wr.data = req.wdata;

    assign gpio_we = req.sel & req.we & gpio_hit;
    assign pwm_we  = {num_pwm{req.sel & req.we}} & pwm_hit;

    // Unmapped addresses read as zero.
    always_comb begin
        read_word = '0;
        if (gpio_hit) begin
            read_word = gpio_rdata;
        end
        for (int i = 0; i < num_pwm; i++) begin
            if (pwm_hit[i]) begin
                read_word = pwm_rdata[i] & data_mask;
            end
        end
    end

    // Holds the last read until the next one.
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (req.sel && !req.we) begin
            rdata <= read_word;
        end
    end

    // No two blocks ever take the same write.
    a_we_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({gpio_we, pwm_we})
    ) else $error("more than one block write strobe active");

endmodule

/* pwm_channel.sv */
// One PWM generator with period, duty, enable and a free-running counter.

`timescale 1ns/1ns

module pwm_channel #(
    // Counter, period and duty width.
    parameter int pwm_width = 16
)(
    input  logic                clk,
    input  logic                rst,

    // Register write for this channel.
    input  logic                we,
    input  periph_pkg::reg_wr_t wr,

    // Word selected by wr.off.
    output logic [31:0]         cfg_rdata,

    // Registered compare output.
    output logic                pwm
);
    logic [pwm_width-1:0] period;
    logic [pwm_width-1:0] duty;
    logic                 en;
    logic [pwm_width-1:0] count;
    logic                 restart;
    logic                 disabling;

    // Writing period or enable starts a fresh cycle.
    assign restart   = we && (wr.off == periph_pkg::PWM_PERIOD || wr.off == periph_pkg::PWM_EN);
    assign disabling = we && wr.off == periph_pkg::PWM_EN && !wr.data[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            period <= '0;
            duty   <= '0;
            en     <= 1'b0;
            count  <= '0;
            pwm    <= 1'b0;
        end else begin
            if (we) begin
                case (wr.off)
                    periph_pkg::PWM_PERIOD: period <= wr.data[pwm_width-1:0];
                    periph_pkg::PWM_DUTY:   duty   <= wr.data[pwm_width-1:0];
                    periph_pkg::PWM_EN:     en     <= wr.data[0];
                    default: ;
                endcase
            end

            if (restart || !en || count >= period) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end

            // Compare lags the counter by one cycle.
            pwm <= en && !disabling && (count < duty);
        end
    end

    always_comb begin
        case (wr.off)
            periph_pkg::PWM_PERIOD: cfg_rdata = 32'(period);
            periph_pkg::PWM_DUTY:   cfg_rdata = 32'(duty);
            periph_pkg::PWM_EN:     cfg_rdata = 32'(en);
            periph_pkg::PWM_COUNT:  cfg_rdata = 32'(count);
            default:                cfg_rdata = '0;
        endcase
    end

    // A disabled channel never drives its pin high.
    a_off_low: assert property (
        @(posedge clk) disable iff (rst)
        !en |-> !pwm
    ) else $error("pwm high while channel disabled");

endmodule

/* gpio_port.sv */
// GPIO output, enable and select registers, PWM merge and input synchronizer.

`timescale 1ns/1ns

module gpio_port #(
    // Number of low pins that can carry a PWM waveform.
    parameter int num_pwm = 4
)(
    input  logic                clk,
    input  logic                rst,

    // Register write for the GPIO block.
    input  logic                we,
    input  periph_pkg::reg_wr_t wr,

    // Word selected by wr.off.
    output logic [31:0]         gpio_rdata,

    // Waveforms from the PWM channels.
    input  logic [num_pwm-1:0]  pwm,

    // Pins.
    output logic [31:0]         pin_out,
    output logic [31:0]         pin_oe,
    input  logic [31:0]         pin_in
);
    logic [31:0]        out_reg;
    logic [31:0]        oe_reg;
    logic [num_pwm-1:0] sel_reg;
    logic [31:0]        in_meta;
    logic [31:0]        in_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_reg <= '0;
            oe_reg  <= '0;
            sel_reg <= '0;
        end else if (we) begin
            case (wr.off)
                periph_pkg::GPIO_OUT: out_reg <= wr.data;
                periph_pkg::GPIO_OE:  oe_reg  <= wr.data;
                periph_pkg::GPIO_SEL: sel_reg <= wr.data[num_pwm-1:0];
                default: ;
            endcase
        end
    end

    // Two stage synchronizer for the input pins.
    always_ff @(posedge clk) begin
        if (rst) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= pin_in;
            in_sync <= in_meta;
        end
    end

    // Selected low pins carry the PWM waveform instead of OUT.
    always_comb begin
        pin_out = out_reg;
        for (int i = 0; i < num_pwm; i++) begin
            if (sel_reg[i]) begin
                pin_out[i] = pwm[i];
            end
        end
    end

    assign pin_oe = oe_reg;

    // Unused SEL bits read as zero.
    always_comb begin
        case (wr.off)
            periph_pkg::GPIO_OUT: gpio_rdata = out_reg;
            periph_pkg::GPIO_OE:  gpio_rdata = oe_reg;
            periph_pkg::GPIO_IN:  gpio_rdata = in_sync;
            periph_pkg::GPIO_SEL: gpio_rdata = 32'(sel_reg);
            default:              gpio_rdata = '0;
        endcase
    end

endmodule

/* periph_top.sv */
// Peripheral top level with decoder, PWM channel array and GPIO port.

`timescale 1ns/1ns

module periph_top #(
    // Number of PWM channels, 1 to 8.
    parameter int num_pwm   = 4,
    // PWM counter width.
    parameter int pwm_width = 16
)(
    input  logic                 clk,
    input  logic                 rst,

    // CPU side bus.
    input  periph_pkg::bus_req_t req,
    output logic [31:0]          rdata,

    // GPIO pins.
    output logic [31:0]          pin_out,
    output logic [31:0]          pin_oe,
    input  logic [31:0]          pin_in
);
    periph_pkg::reg_wr_t       wr;
    logic                      gpio_we;
    logic [num_pwm-1:0]        pwm_we;
    logic [31:0]               gpio_rdata;
    logic [num_pwm-1:0][31:0]  pwm_rdata;
    logic [num_pwm-1:0]        pwm;

    periph_decoder #(
        .num_pwm   (num_pwm),
        .pwm_width (pwm_width)
    ) u_decoder (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .wr         (wr),
        .gpio_we    (gpio_we),
        .pwm_we     (pwm_we),
        .gpio_rdata (gpio_rdata),
        .pwm_rdata  (pwm_rdata),
        .rdata      (rdata)
    );

    // Channel i sits at PWM_BASE + i * PWM_STRIDE.
    for (genvar i = 0; i < num_pwm; i++) begin : g_pwm
        pwm_channel #(
            .pwm_width (pwm_width)
        ) u_pwm (
            .clk       (clk),
            .rst       (rst),
            .we        (pwm_we[i]),
            .wr        (wr),
            .cfg_rdata (pwm_rdata[i]),
            .pwm       (pwm[i])
        );
    end

    gpio_port #(
        .num_pwm (num_pwm)
    ) u_gpio (
        .clk        (clk),
        .rst        (rst),
        .we         (gpio_we),
        .wr         (wr),
        .gpio_rdata (gpio_rdata),
        .pwm        (pwm),
        .pin_out    (pin_out),
        .pin_oe     (pin_oe),
        .pin_in     (pin_in)
    );

endmodule

/* tb_periph.sv */
// Testbench for the peripheral block with random bus traffic and a cycle model of the registers.

`timescale 1ns/1ns

module tb_periph;
    logic                 clk = 1'b0;
    logic                 rst;
    periph_pkg::bus_req_t req;
    logic [31:0]          rdata;
    logic [31:0]          pin_out;
    logic [31:0]          pin_oe;
    logic [31:0]          pin_in;

    // Reference model state.
    logic [31:0] m_out;
    logic [31:0] m_oe;
    logic [3:0]  m_sel;
    logic [31:0] m_meta;
    logic [31:0] m_sync;
    logic [31:0] m_rdata;
    logic [15:0] m_period [4];
    logic [15:0] m_duty [4];
    logic        m_en [4];
    logic [15:0] m_count [4];
    logic        m_pwm [4];

    integer seed = 35;
    int     cycles = 0;
    bit     checking = 1'b0;

    periph_top #(
        .num_pwm   (4),
        .pwm_width (16)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .rdata   (rdata),
        .pin_out (pin_out),
        .pin_oe  (pin_oe),
        .pin_in  (pin_in)
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    // One request per cycle that holds until the next call.
    task automatic bus_access(input logic we, input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        req <= {1'b1, we, addr, data};
    endtask

    task automatic bus_idle();
        @(posedge clk);
        req <= '0;
    endtask

    // Cycle model that updates from the values before each edge.
    always @(posedge clk) begin : model
        logic [11:0] a;
        logic [1:0]  off;
        logic [31:0] word;
        logic        gpio_hit;
        logic        pwm_hit;
        logic        we_ch;
        logic        restart;
        logic        stop;
        int          ch;
        a        = req.addr;
        off      = a[3:2];
        ch       = (int'(a) - 256) / 16;
        gpio_hit = a < 12'h010;
        pwm_hit  = a >= 12'h100 && a < 12'h140;
        if (rst) begin
            m_out   = '0;
            m_oe    = '0;
            m_sel   = '0;
            m_meta  = '0;
            m_sync  = '0;
            m_rdata = '0;
            for (int i = 0; i < 4; i++) begin
                m_period[i] = '0;
                m_duty[i]   = '0;
                m_en[i]     = 1'b0;
                m_count[i]  = '0;
                m_pwm[i]    = 1'b0;
            end
        end else begin
            word = '0;
            if (gpio_hit) begin
                case (off)
                    2'd0:    word = m_out;
                    2'd1:    word = m_oe;
                    2'd2:    word = m_sync;
                    default: word = {28'd0, m_sel};
                endcase
            end else if (pwm_hit) begin
                case (off)
                    2'd0:    word = {16'd0, m_period[ch]};
                    2'd1:    word = {16'd0, m_duty[ch]};
                    2'd2:    word = {31'd0, m_en[ch]};
                    default: word = {16'd0, m_count[ch]};
                endcase
            end
            if (req.sel && !req.we) begin
                m_rdata = word;
            end
            for (int i = 0; i < 4; i++) begin
                we_ch   = req.sel && req.we && pwm_hit && ch == i;
                restart = we_ch && (off == 2'd0 || off == 2'd2);
                stop    = we_ch && off == 2'd2 && !req.wdata[0];
                m_pwm[i] = m_en[i] && !stop && (m_count[i] < m_duty[i]);
                if (restart || !m_en[i] || m_count[i] >= m_period[i]) begin
                    m_count[i] = '0;
                end else begin
                    m_count[i] = m_count[i] + 16'd1;
                end
                if (we_ch) begin
                    case (off)
                        2'd0:    m_period[i] = req.wdata[15:0];
                        2'd1:    m_duty[i]   = req.wdata[15:0];
                        2'd2:    m_en[i]     = req.wdata[0];
                        default: ;
                    endcase
                end
            end
            if (req.sel && req.we && gpio_hit) begin
                case (off)
                    2'd0:    m_out = req.wdata;
                    2'd1:    m_oe  = req.wdata;
                    2'd3:    m_sel = req.wdata[3:0];
                    default: ;
                endcase
            end
            m_sync = m_meta;
            m_meta = pin_in;
        end
    end

    // Outputs are stable at the falling edge.
    always @(negedge clk) begin : compare
        logic [31:0] exp_out;
        if (checking) begin
            exp_out = m_out;
            for (int i = 0; i < 4; i++) begin
                if (m_sel[i]) begin
                    exp_out[i] = m_pwm[i];
                end
            end
            check("rdata", rdata, m_rdata);
            check("pin_oe", pin_oe, m_oe);
            check("pin_out", pin_out, exp_out);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= 3000) begin
            $display("timeout: the test did not finish within 3000 cycles");
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] k;
        logic [11:0] addr;
        rst    = 1'b1;
        req    = '0;
        pin_in = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        checking = 1'b1;

        // Everything reads zero after reset.
        @(negedge clk);
        check("pin_out", pin_out, 32'd0);
        check("pin_oe", pin_oe, 32'd0);
        check("rdata", rdata, 32'd0);
        for (int i = 0; i < 20; i++) begin
            addr = (i < 4) ? 12'(i * 4) : 12'(256 + (i - 4) * 4);
            bus_access(1'b0, addr, 32'd0);
            bus_idle();
            @(negedge clk);
            check("rdata after reset", rdata, 32'd0);
        end

        // GPIO traffic over mapped and unmapped addresses.
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            k = {$random(seed)} % 6;
            case (k)
                0:       addr = 12'h000;
                1:       addr = 12'h004;
                2:       addr = 12'h00c;
                3:       addr = 12'h008;
                4:       addr = 12'h200 | (r[11:0] & 12'h9fc);
                default: addr = 12'h040 | (r[11:0] & 12'h0bc);
            endcase
            bus_access(r[31], addr, $random(seed));
        end

        // All four channels running and routed to pins.
        for (int c = 0; c < 4; c++) begin
            r = $random(seed);
            addr = 12'h100 + 12'(c * 16);
            bus_access(1'b1, addr, {26'd0, r[5:0]} + 32'd2);
            bus_access(1'b1, addr + 12'h004, {26'd0, r[21:16]});
            bus_access(1'b1, addr + 12'h008, 32'd1);
        end
        bus_access(1'b1, 12'h00c, 32'h0000_000f);
        for (int n = 0; n < 1000; n++) begin
            r = $random(seed);
            addr = 12'h100 + {6'd0, r[1:0], 4'd0} + {8'd0, r[3:2], 2'd0};
            if (r[9:4] == 6'd0) begin
                bus_access(1'b1, addr, {26'd0, r[31:26]});
            end else if (r[10]) begin
                bus_access(1'b0, {addr[11:4], 4'hc}, 32'd0);
            end else begin
                bus_access(1'b0, addr, 32'd0);
            end
        end

        // Duty above period stays high and a disabled channel stays low.
        bus_access(1'b1, 12'h100, 32'd10);
        bus_access(1'b1, 12'h104, 32'd50);
        bus_access(1'b1, 12'h108, 32'd1);
        bus_access(1'b1, 12'h114, 32'd50);
        bus_access(1'b1, 12'h118, 32'd0);
        bus_access(1'b1, 12'h00c, 32'h0000_0003);
        bus_idle();
        repeat (2) @(posedge clk);
        for (int n = 0; n < 40; n++) begin
            @(negedge clk);
            check("pin_out[0]", pin_out & 32'h1, 32'h1);
            check("pin_out[1]", pin_out & 32'h2, 32'h0);
        end
        bus_access(1'b1, 12'h000, 32'h0000_0002);
        bus_access(1'b1, 12'h00c, 32'h0000_0001);
        bus_idle();
        @(negedge clk);
        check("pin_out[1]", pin_out & 32'h2, 32'h2);

        // Input pins read back through the synchronizer.
        for (int n = 0; n < 60; n++) begin
            @(posedge clk);
            pin_in <= $random(seed);
            req    <= {1'b1, 1'b0, 12'h008, 32'd0};
        end
        bus_idle();
        repeat (3) @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* all.f */
periph_pkg.sv
periph_decoder.sv
pwm_channel.sv
gpio_port.sv
periph_top.sv
tb_periph.sv

/* Makefile */
# Verilator build and run of the peripheral testbench.

obj_dir/Vtb_periph: all.f periph_pkg.sv periph_decoder.sv pwm_channel.sv gpio_port.sv periph_top.sv tb_periph.sv
	verilator --binary --top-module tb_periph -f all.f

run: obj_dir/Vtb_periph
	./obj_dir/Vtb_periph > sim.log 2>&1 || true
	cat sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
